// ==== verilog.f ====
llspi_pkg.sv
shortfifo.sv
spi_eater.sv
spi_pin_mux.sv
llspi.sv
tb_clk_gen.sv
tb_spi_devices.sv
llspi_tb.sv

// ==== llspi_tb.sv ====
`timescale 1ns/1ps

module llspi_tb;

	import llspi_pkg::*;

	localparam int PACE_SET    = 3;
	// clocks per half sclk period
	localparam int HALF        = 1 << (PACE_SET - 1);
	// 16 half periods per byte plus pull, load and router delay
	localparam int BYTE_CYCLES = 16 * HALF + 8;
	localparam int N_TESTS     = 6;
	// the loop-back test is the longest with 80 bytes
	localparam int MAX_BYTES   = 80;
	localparam int CYCLE_LIMIT = N_TESTS * MAX_BYTES * 16 * HALF * 2;

	logic       clk;
	logic       rst_n;
	host_word_t host_din;
	logic       host_we;
	logic       result_re;
	logic [7:0] host_result;
	status_t    status;
	main_pins_t main;
	poll_pins_t poll;
	logic       sdo;
	logic       sdio_drive;
	miso_pins_t pins_in;

	logic [15:0] lfsr = 16'd55;
	// last byte each chip holds by select code
	logic [7:0]  mirror [8];
	logic [7:0]  want_q [$];

	int         errors;
	int         test_errors;
	int         tests_failed;
	int         cycles;
	int         main_edges;
	int         poll_edges;
	int         sel_moves;
	logic       main_sclk_q;
	logic       poll_sclk_q;
	logic [5:0] sel_last;

	tb_clk_gen #(.HALF_PERIOD(50), .RESET_CYCLES(16)) clk_gen (.clk(clk), .rst_n(rst_n));

	llspi #(.PACE_SET(PACE_SET)) UUT (
		.clk(clk), .rst_n(rst_n),
		.host_din(host_din), .host_we(host_we), .result_re(result_re),
		.host_result(host_result), .status(status),
		.main(main), .poll(poll), .sdo(sdo), .sdio_drive(sdio_drive),
		.pins_in(pins_in)
	);

	tb_spi_devices devices (
		.main(main), .poll(poll), .sdo(sdo), .sdio_drive(sdio_drive), .pins_in(pins_in)
	);

	// run limit
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Something failed");
			$finish;
		end
	end

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic draw(input int nbits, output logic [7:0] val);
		val = 8'h00;
		for (int i = 0; i < nbits; i++) begin
			lfsr = lfsr_step(lfsr);
			val = {val[6:0], lfsr[0]};
		end
	endtask

	function automatic logic [5:0] sel_lines();
		return {main.lmk_le, main.adc_csb0, main.adc_csb1, main.dac_csb,
			poll.amc_ss, poll.sdc_csb};
	endfunction

	// pins expected with the bus at rest
	function automatic main_pins_t exp_main(input chip_sel_e sel, input logic rd);
		main_pins_t m;
		// every select idle high to start with
		m = '0;
		m.lmk_le   = 1'b1;
		m.adc_csb0 = 1'b1;
		m.adc_csb1 = 1'b1;
		m.dac_csb  = 1'b1;
		m.sdio_dir = !rd;
		case (sel)
			sel_lmk: m.lmk_le = 1'b0;
			sel_adc0: m.adc_csb0 = 1'b0;
			sel_adc1: m.adc_csb1 = 1'b0;
			sel_dac: m.dac_csb = 1'b0;
			sel_adc_both: begin
				m.adc_csb0 = 1'b0;
				m.adc_csb1 = 1'b0;
			end
			default: ;
		endcase
		return m;
	endfunction

	function automatic poll_pins_t exp_poll(input chip_sel_e sel);
		poll_pins_t p;
		p = '0;
		p.amc_ss  = 1'b1;
		p.sdc_csb = 1'b1;
		case (sel)
			sel_amc: p.amc_ss = 1'b0;
			sel_sdc: p.sdc_csb = 1'b0;
			default: ;
		endcase
		return p;
	endfunction

	function automatic status_t status_of(input logic [3:0] cnt);
		status_t s;
		s = '0;
		s.in_empty     = 1'b1;
		s.result_count = cnt;
		return s;
	endfunction

	// byte the selected chip returns and zero for write-only LMK
	function automatic logic [7:0] expect_read(input chip_sel_e sel, input logic rd);
		case (sel)
			sel_adc0, sel_adc_both: return rd ? mirror[2] : 8'h00;
			sel_adc1: return rd ? mirror[3] : 8'h00;
			sel_dac, sel_amc, sel_sdc: return mirror[int'(sel)];
			default: return 8'h00;
		endcase
	endfunction

	// ADCs only take the byte on write cycles
	task automatic note_write(input chip_sel_e sel, input logic rd, input logic [7:0] b);
		case (sel)
			sel_none: ;
			sel_adc0: if (!rd) mirror[2] = b;
			sel_adc1: if (!rd) mirror[3] = b;
			sel_adc_both: begin
				if (!rd) begin
					mirror[2] = b;
					mirror[3] = b;
				end
			end
			default: mirror[int'(sel)] = b;
		endcase
	endtask

	task automatic count_error();
		errors++;
		test_errors++;
	endtask

	task automatic note_fail(input string msg);
		$display("%s (at %0t)", msg, $time);
		count_error();
	endtask

	task automatic check_result(input string what, input logic [7:0] got,
		input logic [7:0] want);
		if (got !== want) begin
			$display("ERROR %0t: %s got %02h expected %02h", $time, what, got, want);
			count_error();
		end
	endtask

	task automatic check_status(input status_t got, input status_t want);
		if (got !== want) begin
			$display("ERROR %0t: status got %02h expected %02h", $time, got, want);
			count_error();
		end
	endtask

	task automatic check_pins(input main_pins_t got_m, input main_pins_t want_m,
		input poll_pins_t got_p, input poll_pins_t want_p);
		if (got_m !== want_m || got_p !== want_p) begin
			$display("ERROR %0t: pins main %02h poll %01h expected main %02h poll %01h",
				$time, got_m, got_p, want_m, want_p);
			count_error();
		end
	endtask

	// one clock of counting sclk rising edges and select line changes
	task automatic watch_cycle();
		logic [5:0] now;
		@(negedge clk);
		now = sel_lines();
		if (main.sclk && !main_sclk_q) begin
			main_edges++;
		end
		if (poll.poll_sclk && !poll_sclk_q) begin
			poll_edges++;
		end
		if (now != sel_last) begin
			sel_moves++;
		end
		main_sclk_q = main.sclk;
		poll_sclk_q = poll.poll_sclk;
		sel_last    = now;
	endtask

	task automatic push_word(input host_word_t w);
		@(negedge clk);
		host_din = w;
		host_we  = 1'b1;
		@(negedge clk);
		host_we  = 1'b0;
	endtask

	task automatic wait_empty(input int limit);
		int n;
		n = 0;
		while (!status.in_empty && n < limit) begin
			watch_cycle();
			n++;
		end
		if (!status.in_empty) begin
			note_fail("input FIFO never drained");
		end
	endtask

	task automatic send_ctl(input chip_sel_e sel, input logic rd, input logic cap);
		host_word_t w;
		w = '0;
		w.is_ctl                    = 1'b1;
		w.payload.ctl.sel           = sel;
		w.payload.ctl.sdio_read     = rd;
		w.payload.ctl.capture       = cap;
		push_word(w);
		wait_empty(BYTE_CYCLES);
		// router follows a clock after the engine
		repeat (2) @(negedge clk);
	endtask

	task automatic pop_result(output logic [7:0] got);
		@(negedge clk);
		result_re = 1'b1;
		@(negedge clk);
		result_re = 1'b0;
		got = host_result;
	endtask

	// one data byte with the result checked when capture is on
	task automatic transfer(input logic [7:0] data, input logic cap, input logic [7:0] want);
		host_word_t w;
		logic [7:0] got;
		int         n;
		main_edges  = 0;
		poll_edges  = 0;
		sel_moves   = 0;
		main_sclk_q = main.sclk;
		poll_sclk_q = poll.poll_sclk;
		sel_last    = sel_lines();
		w = '0;
		w.payload.data = data;
		push_word(w);
		wait_empty(BYTE_CYCLES);
		if (cap) begin
			n = 0;
			while (status.result_count == 4'd0 && n < 2 * BYTE_CYCLES) begin
				watch_cycle();
				n++;
			end
			if (status.result_count == 4'd0) begin
				note_fail("no result byte arrived for a captured transfer");
			end else begin
				pop_result(got);
				check_result("read back", got, want);
			end
		end else begin
			repeat (BYTE_CYCLES) watch_cycle();
		end
		check_status(status, status_of(4'd0));
	endtask

	task automatic finish_test(input int num, input string name);
		if (test_errors == 0) begin
			$display("test %0d %s: pass", num, name);
		end else begin
			$display("test %0d %s: fail, %0d errors", num, name, test_errors);
			tests_failed++;
		end
		test_errors = 0;
	endtask

	initial begin
		logic [7:0] r;
		logic [7:0] b;
		logic [7:0] got;
		chip_sel_e  sel;
		logic       is_adc;
		host_word_t w;
		host_din  = '0;
		host_we   = 1'b0;
		result_re = 1'b0;
		for (int i = 0; i < 8; i++) begin
			mirror[i] = 8'h00;
		end
		@(posedge rst_n);
		@(negedge clk);

		// test 1 checks the reset state
		check_status(status, status_of(4'd0));
		check_pins(main, exp_main(sel_none, 1'b0), poll, exp_poll(sel_none));
		check_result("host_result after reset", host_result, 8'hcc);
		finish_test(1, "reset state");

		// test 2 covers select decode and bus split with adc_both on the first pass
		for (int i = 0; i < 8; i++) begin
			draw(3, r);
			sel = (i == 0) ? sel_adc_both : chip_sel_e'(r[2:0]);
			send_ctl(sel, 1'b0, 1'b0);
			check_pins(main, exp_main(sel, 1'b0), poll, exp_poll(sel));
			draw(8, b);
			transfer(b, 1'b0, 8'h00);
			note_write(sel, 1'b0, b);
			if (sel == sel_amc || sel == sel_sdc) begin
				check_result("poll sclk edges", poll_edges[7:0], 8'd8);
				check_result("main sclk edges", main_edges[7:0], 8'd0);
			end else begin
				check_result("main sclk edges", main_edges[7:0], 8'd8);
				check_result("poll sclk edges", poll_edges[7:0], 8'd0);
			end
		end
		finish_test(2, "chip select");

		// test 3 loop-back where the second transfer returns the first byte
		for (int i = 0; i < 40; i++) begin
			draw(3, r);
			sel = (r[2:0] == 3'd0) ? sel_dac : chip_sel_e'(r[2:0]);
			is_adc = (sel == sel_adc0 || sel == sel_adc1 || sel == sel_adc_both);
			draw(8, b);
			send_ctl(sel, 1'b0, 1'b1);
			transfer(b, 1'b1, expect_read(sel, 1'b0));
			note_write(sel, 1'b0, b);
			send_ctl(sel, is_adc, 1'b1);
			// ADC reads turn the data pin buffer around
			check_pins(main, exp_main(sel, is_adc), poll, exp_poll(sel));
			draw(8, b);
			transfer(b, 1'b1, expect_read(sel, is_adc));
			note_write(sel, is_adc, b);
		end
		finish_test(3, "capture loop-back");

		// test 4 with capture off leaves the result FIFO alone
		draw(3, r);
		sel = (r[2:0] == 3'd0) ? sel_amc : chip_sel_e'(r[2:0]);
		send_ctl(sel, 1'b0, 1'b0);
		for (int i = 0; i < 4; i++) begin
			draw(8, b);
			transfer(b, 1'b0, 8'h00);
			note_write(sel, 1'b0, b);
		end
		finish_test(4, "capture off");

		// test 5 pushes 17 captured bytes into a 16 deep result FIFO
		draw(2, r);
		sel = (r[1:0] == 2'd0) ? sel_dac : ((r[1:0] == 2'd1) ? sel_amc : sel_sdc);
		send_ctl(sel, 1'b0, 1'b1);
		want_q.delete();
		for (int i = 0; i < 17; i++) begin
			draw(8, b);
			w = '0;
			w.payload.data = b;
			push_word(w);
			if (i < 16) begin
				want_q.push_back(expect_read(sel, 1'b0));
			end
			note_write(sel, 1'b0, b);
		end
		wait_empty(20 * BYTE_CYCLES);
		repeat (BYTE_CYCLES) watch_cycle();
		// a full FIFO shows as 15 in the 4-bit count
		check_status(status, status_of(4'hf));
		for (int i = 0; i < 16; i++) begin
			pop_result(got);
			check_result("burst pop", got, want_q[i]);
		end
		check_status(status, status_of(4'd0));
		finish_test(5, "burst fill");

		// test 6 with nothing selected reads zero and moves no select line
		send_ctl(sel_none, 1'b0, 1'b1);
		check_pins(main, exp_main(sel_none, 1'b0), poll, exp_poll(sel_none));
		draw(8, b);
		transfer(b, 1'b1, 8'h00);
		check_result("select line moves", sel_moves[7:0], 8'd0);
		check_pins(main, exp_main(sel_none, 1'b0), poll, exp_poll(sel_none));
		finish_test(6, "select none");

		$display("%0d tests run, %0d failed, %0d errors", N_TESTS, tests_failed, errors);
		if (errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

// ==== tb_spi_devices.sv ====
`timescale 1ns/1ps

// one chip that shifts in on rising sck and shifts out its previous byte
module loopback_chip (
	input  logic csb,
	input  logic sck,
	input  logic din,
	// low keeps the held byte during ADC read cycles
	input  logic store,
	output logic dout
);

	logic [7:0] rx   = 8'h00;
	logic [7:0] tx   = 8'h00;
	logic [7:0] held = 8'h00;
	logic [2:0] cnt  = 3'd0;

	always @(posedge sck) begin
		if (!csb) begin
			rx  <= {rx[6:0], din};
			cnt <= cnt + 3'd1;
			// eighth bit closes the byte
			if (cnt == 3'd7 && store) begin
				held <= {rx[6:0], din};
			end
		end
	end

	always @(negedge sck) begin
		if (!csb) begin
			// counter wrapped so the next transfer starts with the new byte
			if (cnt == 3'd0) begin
				tx <= held;
			end else begin
				tx <= {tx[6:0], 1'b0};
			end
		end
	end

	assign dout = tx[7];

endmodule

module tb_spi_devices (
	input  llspi_pkg::main_pins_t main,
	input  llspi_pkg::poll_pins_t poll,
	input  logic                  sdo,
	input  logic                  sdio_drive,
	output llspi_pkg::miso_pins_t pins_in
);

	logic adc0_out;
	logic adc1_out;
	logic dac_out;
	logic amc_out;
	logic sdc_out;

	// main bus chips, LMK is write only
	loopback_chip lmk (.csb(main.lmk_le), .sck(main.sclk), .din(main.sdi),
		.store(1'b1), .dout());
	loopback_chip adc0 (.csb(main.adc_csb0), .sck(main.sclk), .din(sdo),
		.store(sdio_drive), .dout(adc0_out));
	loopback_chip adc1 (.csb(main.adc_csb1), .sck(main.sclk), .din(sdo),
		.store(sdio_drive), .dout(adc1_out));
	loopback_chip dac (.csb(main.dac_csb), .sck(main.sclk), .din(main.sdi),
		.store(1'b1), .dout(dac_out));
	// poll bus chips
	loopback_chip amc (.csb(poll.amc_ss), .sck(poll.poll_sclk), .din(poll.poll_mosi),
		.store(1'b1), .dout(amc_out));
	loopback_chip sdc (.csb(poll.sdc_csb), .sck(poll.poll_sclk), .din(poll.poll_mosi),
		.store(1'b1), .dout(sdc_out));

	// ADCs drive the shared pin only once it is turned around
	// ADC0 wins the pin when both are selected
	assign pins_in.adc_sdi = sdio_drive ? 1'b0 :
		(!main.adc_csb0 ? adc0_out : (!main.adc_csb1 ? adc1_out : 1'b0));
	assign pins_in.dac_sdo  = dac_out;
	assign pins_in.amc_miso = amc_out;
	assign pins_in.sdc_dout = sdc_out;

endmodule

// ==== tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen #(
	parameter int HALF_PERIOD  = 50,
	parameter int RESET_CYCLES = 16
) (
	output logic clk,
	output logic rst_n
);

	// free running clock, 100 ns period by default
	initial begin
		clk = 1'b0;
		forever #(HALF_PERIOD) clk = ~clk;
	end

	// reset low for a count of rising edges, released on a falling edge
	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
	end

endmodule

// ==== llspi.sv ====
`timescale 1ns/1ps

module llspi #(
	parameter int PACE_SET = 6,
	parameter int IN_AW    = 5
) (
	input  logic                  clk,
	input  logic                  rst_n,
	// host side
	input  llspi_pkg::host_word_t host_din,
	input  logic                  host_we,
	input  logic                  result_re,
	output logic [7:0]            host_result,
	output llspi_pkg::status_t    status,
	// board pins
	output llspi_pkg::main_pins_t main,
	output llspi_pkg::poll_pins_t poll,
	output logic                  sdo,
	output logic                  sdio_drive,
	input  llspi_pkg::miso_pins_t pins_in
);

	import llspi_pkg::*;

	// free running divider, top bit sets the bit rate
	logic [PACE_SET-1:0] pace_cnt;
	logic                pace;

	logic       in_empty;
	logic       pull;
	host_word_t fdata;

	logic       result_we;
	logic [7:0] result;
	logic [7:0] result_head;
	logic [4:0] result_count;

	logic       sclk;
	logic       mosi;
	logic       miso;
	spi_ctl_t   ctl;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pace_cnt <= '0;
		end else begin
			pace_cnt <= pace_cnt + 1'b1;
		end
	end

	assign pace = pace_cnt[PACE_SET-1];

	// host command words
	shortfifo #(.DW(9), .AW(IN_AW)) input_fifo (
		.clk(clk), .rst_n(rst_n),
		.we(host_we), .din(host_din),
		.re(pull), .dout(fdata),
		.full(), .empty(in_empty), .count()
	);

	spi_eater eater (
		.clk(clk), .rst_n(rst_n), .pace(pace),
		.empty(in_empty), .fdata(fdata), .pull(pull),
		.result_we(result_we), .result(result),
		.sclk(sclk), .mosi(mosi), .ctl(ctl), .miso(miso)
	);

	spi_pin_mux pin_mux (
		.clk(clk), .rst_n(rst_n),
		.sclk(sclk), .mosi(mosi), .ctl(ctl),
		.main(main), .poll(poll),
		.sdo(sdo), .sdio_drive(sdio_drive),
		.pins_in(pins_in), .miso(miso)
	);

	// bytes read back, waiting for the host
	shortfifo #(.DW(8), .AW(4)) result_fifo (
		.clk(clk), .rst_n(rst_n),
		.we(result_we), .din(result),
		.re(result_re), .dout(result_head),
		.full(), .empty(), .count(result_count)
	);

	// popped byte held for the host, valid the cycle after the strobe
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			host_result <= 8'hcc;
		end else if (result_re) begin
			host_result <= result_head;
		end
	end

	// a full result FIFO reads as 15 in the 4-bit field
	assign status.zero         = 3'b000;
	assign status.in_empty     = in_empty;
	assign status.result_count = result_count[4] ? 4'hf : result_count[3:0];

endmodule

// ==== spi_pin_mux.sv ====
`timescale 1ns/1ps

module spi_pin_mux (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  sclk,
	input  logic                  mosi,
	input  llspi_pkg::spi_ctl_t   ctl,
	output llspi_pkg::main_pins_t main,
	output llspi_pkg::poll_pins_t poll,
	// shared ADC data pin, split into value and drive enable
	output logic                  sdo,
	output logic                  sdio_drive,
	input  llspi_pkg::miso_pins_t pins_in,
	output logic                  miso
);

	import llspi_pkg::*;

	logic       adc_sel;
	logic       poll_sel;
	// returning lines after one register stage
	miso_pins_t grab;

	// either ADC, alone or both together
	assign adc_sel  = (ctl.sel == sel_adc0) || (ctl.sel == sel_adc1) ||
		(ctl.sel == sel_adc_both);
	// monitor chips live on the isolated bus
	assign poll_sel = (ctl.sel == sel_amc) || (ctl.sel == sel_sdc);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			// nothing selected, clocks and data parked low
			main <= '{
				sclk: 1'b0,
				sdi: 1'b0,
				lmk_le: 1'b1,
				adc_csb0: 1'b1,
				adc_csb1: 1'b1,
				dac_csb: 1'b1,
				sdio_dir: 1'b1,
				spare: 1'b0
			};
			poll <= '{
				poll_sclk: 1'b0,
				poll_mosi: 1'b0,
				amc_ss: 1'b1,
				sdc_csb: 1'b1
			};
			sdo        <= 1'b0;
			sdio_drive <= 1'b1;
		end else begin
			// main bus stays quiet while the poll bus is in use
			main.sclk     <= sclk & ~poll_sel;
			main.sdi      <= mosi & ~poll_sel;
			main.lmk_le   <= (ctl.sel != sel_lmk);
			main.adc_csb0 <= !((ctl.sel == sel_adc0) || (ctl.sel == sel_adc_both));
			main.adc_csb1 <= !((ctl.sel == sel_adc1) || (ctl.sel == sel_adc_both));
			main.dac_csb  <= (ctl.sel != sel_dac);
			// board level buffer direction, high means FPGA drives
			main.sdio_dir <= ~ctl.sdio_read;
			main.spare    <= 1'b0;
			poll.poll_sclk <= sclk & poll_sel;
			poll.poll_mosi <= mosi & poll_sel;
			poll.amc_ss    <= (ctl.sel != sel_amc);
			poll.sdc_csb   <= (ctl.sel != sel_sdc);
			// ADC gets mosi only on write cycles
			sdo        <= mosi & adc_sel & ~ctl.sdio_read;
			sdio_drive <= ~ctl.sdio_read;
		end
	end

	// input registers, plain data so no reset
	always_ff @(posedge clk) begin
		grab <= pins_in;
	end

	// pick the line of the selected chip
	always_comb begin
		case (ctl.sel)
			sel_adc0:     miso = grab.adc_sdi;
			sel_adc1:     miso = grab.adc_sdi;
			sel_adc_both: miso = grab.adc_sdi;
			sel_dac:      miso = grab.dac_sdo;
			sel_amc:      miso = grab.amc_miso;
			sel_sdc:      miso = grab.sdc_dout;
			// LMK is write only
			default:      miso = 1'b0;
		endcase
	end

endmodule

// ==== spi_eater.sv ====
`timescale 1ns/1ps

module spi_eater (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   pace,
	// command FIFO side
	input  logic                   empty,
	input  llspi_pkg::host_word_t  fdata,
	output logic                   pull,
	// result FIFO side
	output logic                   result_we,
	output logic [7:0]             result,
	// toward the pin router
	output logic                   sclk,
	output logic                   mosi,
	output llspi_pkg::spi_ctl_t    ctl,
	input  logic                   miso
);

	import llspi_pkg::*;

	typedef enum logic [1:0] {
		st_idle,
		st_load,
		st_shift
	} state_e;

	state_e     state;
	// previous pace, any change is one half sclk period
	logic       pace_d;
	logic       tick;
	// shifts mosi out at the top, miso in at the bottom
	logic [7:0] sreg;
	logic [2:0] bit_cnt;
	// idle with a word waiting and no pop still in flight
	logic       take;

	assign tick = pace ^ pace_d;
	assign take = (state == st_idle) && !empty && !pull;

	// the received byte is complete in sreg when result_we rises
	assign result = sreg;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state     <= st_idle;
			pace_d    <= 1'b0;
			pull      <= 1'b0;
			result_we <= 1'b0;
			sclk      <= 1'b0;
			mosi      <= 1'b0;
			bit_cnt   <= 3'd0;
			ctl       <= '{sel: sel_none, sdio_read: 1'b0, capture: 1'b0};
		end else begin
			pace_d    <= pace;
			// both strobes last a single cycle
			pull      <= 1'b0;
			result_we <= 1'b0;
			case (state)
				st_idle: begin
					if (take) begin
						pull <= 1'b1;
						if (fdata.is_ctl) begin
							// control word applies right away, no bus activity
							ctl.sel       <= fdata.payload.ctl.sel;
							ctl.sdio_read <= fdata.payload.ctl.sdio_read;
							ctl.capture   <= fdata.payload.ctl.capture;
						end else begin
							state <= st_load;
						end
					end
				end
				st_load: begin
					// first bit goes out ahead of the first rising sclk
					mosi    <= sreg[7];
					bit_cnt <= 3'd0;
					state   <= st_shift;
				end
				st_shift: begin
					if (tick) begin
						if (!sclk) begin
							// rising half, miso sampled into sreg below
							sclk <= 1'b1;
						end else begin
							// falling half, next bit or end of byte
							sclk    <= 1'b0;
							bit_cnt <= bit_cnt + 3'd1;
							if (bit_cnt == 3'd7) begin
								mosi      <= 1'b0;
								result_we <= ctl.capture;
								state     <= st_idle;
							end else begin
								mosi <= sreg[7];
							end
						end
					end
				end
				default: begin
					state <= st_idle;
				end
			endcase
		end
	end

	// payload path
	always_ff @(posedge clk) begin
		if (take && !fdata.is_ctl) begin
			sreg <= fdata.payload.data;
		end else if (state == st_shift && tick && !sclk) begin
			// mosi already holds the old top bit
			sreg <= {sreg[6:0], miso};
		end
	end

endmodule

// ==== shortfifo.sv ====
`timescale 1ns/1ps

module shortfifo #(
	parameter int DW = 8,
	parameter int AW = 4
) (
	input  logic          clk,
	input  logic          rst_n,
	input  logic          we,
	input  logic [DW-1:0] din,
	input  logic          re,
	output logic [DW-1:0] dout,
	output logic          full,
	output logic          empty,
	output logic [AW:0]   count
);

	localparam int DEPTH = 1 << AW;

	// storage, no reset needed
	logic [DW-1:0] mem [DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [AW:0]   occ;
	logic          do_push;
	logic          do_pop;

	// disallowed requests are simply ignored
	assign do_push = we && !full;
	assign do_pop  = re && !empty;

	// write side
	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= din;
		end
	end

	// pointers and occupancy
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			occ    <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			// simultaneous push and pop leaves the count alone
			if (do_push && !do_pop) begin
				occ <= occ + 1'b1;
			end else if (do_pop && !do_push) begin
				occ <= occ - 1'b1;
			end
		end
	end

	// head word shows at dout without a read, so a pop just advances
	assign dout  = mem[rd_ptr];
	assign full  = (occ == DEPTH[AW:0]);
	assign empty = (occ == '0);
	assign count = occ;

endmodule

// ==== llspi_pkg.sv ====
package llspi_pkg;

	// chip selected on the slow-control bus
	// adc_both selects both ADCs together, used to sync their test pattern
	typedef enum logic [2:0] {
		sel_none     = 3'd0,
		sel_lmk      = 3'd1,
		sel_adc0     = 3'd2,
		sel_adc1     = 3'd3,
		sel_dac      = 3'd4,
		sel_adc_both = 3'd5,
		sel_amc      = 3'd6,
		sel_sdc      = 3'd7
	} chip_sel_e;

	// low byte of a control word
	typedef struct packed {
		logic [1:0] spare_hi;
		// push received bytes into the result FIFO
		logic       capture;
		// shared ADC data pin turned around to an input
		logic       sdio_read;
		logic       spare_lo;
		chip_sel_e  sel;
	} ctl_fields_t;

	// same byte seen as shift data or as control fields
	typedef union packed {
		logic [7:0]  data;
		ctl_fields_t ctl;
	} payload_u;

	// 9-bit word written by the host
	typedef struct packed {
		logic     is_ctl;
		payload_u payload;
	} host_word_t;

	// setting held by the engine between control words
	typedef struct packed {
		chip_sel_e sel;
		logic      sdio_read;
		logic      capture;
	} spi_ctl_t;

	// main bus toward LMK, ADCs and DAC
	typedef struct packed {
		logic sclk;
		logic sdi;
		logic lmk_le;
		logic adc_csb0;
		logic adc_csb1;
		logic dac_csb;
		logic sdio_dir;
		logic spare;
	} main_pins_t;

	// isolated poll bus toward the AMC and SDC monitor chips
	typedef struct packed {
		logic poll_sclk;
		logic poll_mosi;
		logic amc_ss;
		logic sdc_csb;
	} poll_pins_t;

	// returning data lines, one per readable chip
	typedef struct packed {
		logic adc_sdi;
		logic dac_sdo;
		logic amc_miso;
		logic sdc_dout;
	} miso_pins_t;

	// host-visible status word
	typedef struct packed {
		logic [2:0] zero;
		logic       in_empty;
		logic [3:0] result_count;
	} status_t;

endpackage
